/* common/decode_consts.svh */
////////////////////////////////////////
// Decode constants
// Instruction width, major opcodes and M enable reset value
////////////////////////////////////////
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define INSTR_W      32      // RV32 only

// Major opcode field, instr[6:0]
`define OPC_LOAD     7'h03
`define OPC_MISC_MEM 7'h0f
`define OPC_OP_IMM   7'h13
`define OPC_AUIPC    7'h17
`define OPC_STORE    7'h23
`define OPC_OP       7'h33
`define OPC_LUI      7'h37
`define OPC_BRANCH   7'h63
`define OPC_JALR     7'h67
`define OPC_JAL      7'h6f
`define OPC_SYSTEM   7'h73

`define M_EN_RST     1'b1    // M extension on out of reset

`endif

/* common/decode_pkg.sv */
////////////////////////////////////////
// Decode types
// Operator enums, mux selects and the decoder control word
////////////////////////////////////////
package decode_pkg;

  // ALU operations, branch compares included
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_opcode_e;

  // Encoded as funct3[1:0] of the M instructions
  typedef enum logic [1:0] {MUL_M, MUL_H, MUL_HSU, MUL_HU} mul_opcode_e;
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_opcode_e;

  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_opcode_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  ////////////////////////////////////////
  // Control word
  ////////////////////////////////////////
  typedef struct packed {
    logic        alu_en;
    logic        alu_bch;        // ALU does branch compare
    logic        alu_jmp;        // JAL or JALR
    alu_opcode_e alu_operator;
    op_a_sel_e   op_a_sel;
    op_b_sel_e   op_b_sel;
    imm_sel_e    imm_sel;
    logic        mul_en;
    mul_opcode_e mul_operator;
    logic        div_en;
    div_opcode_e div_operator;
    logic        lsu_en;
    logic        lsu_we;         // Store
    logic [1:0]  lsu_size;       // Byte, half, word
    logic        lsu_sext;
    logic        csr_en;
    csr_opcode_e csr_op;
    logic        rf_we;
    logic [1:0]  rf_re;          // Bit 0 rs1, bit 1 rs2
    logic        sys_en;
    logic        sys_ecall;
    logic        sys_ebrk;
    logic        sys_mret;
    logic        sys_wfi;
    logic        sys_fencei;
    logic        illegal_insn;
  } decoder_ctrl_t;

  // No match, every enable low
  parameter decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    alu_operator: ALU_ADD, op_a_sel: OP_A_REG, op_b_sel: OP_B_REG, imm_sel: IMM_I,
    mul_operator: MUL_M, div_operator: DIV_DIV, csr_op: CSR_OP_READ,
    illegal_insn: 1'b1, default: '0};

endpackage

/* common/pipe_pkg.sv */
////////////////////////////////////////
// Pipeline stage types
// IF/ID input and ID/EX output of the decode stage
////////////////////////////////////////
`include "decode_consts.svh"

package pipe_pkg;

  ////////////////////////////////////////
  // IF/ID
  ////////////////////////////////////////
  typedef struct packed {
    logic                instr_valid;
    logic [`INSTR_W-1:0] instr;
    logic                illegal_c_insn;   // Bad compressed encoding seen in IF
  } if_id_pipe_t;

  ////////////////////////////////////////
  // ID/EX
  ////////////////////////////////////////
  typedef struct packed {
    logic                      valid;
    decode_pkg::decoder_ctrl_t ctrl;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [4:0]                rd;
  } id_ex_pipe_t;

endpackage

/* decoder/i_decoder.sv */
////////////////////////////////////////
// RV32I decoder
// Base integer set to control word, illegal on no match
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_consts.svh"

module i_decoder (
  input  logic [`INSTR_W-1:0]       instr_i,
  output decode_pkg::decoder_ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;
  decode_pkg::decoder_ctrl_t ctrl;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register and immediate ALU forms share the funct3 map
  function automatic decode_pkg::alu_opcode_e alu_op(input logic [2:0] f3, input logic alt);
    decode_pkg::alu_opcode_e op;
    case (f3)
      3'd0:    op = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
      3'd1:    op = decode_pkg::ALU_SLL;
      3'd2:    op = decode_pkg::ALU_SLT;
      3'd3:    op = decode_pkg::ALU_SLTU;
      3'd4:    op = decode_pkg::ALU_XOR;
      3'd5:    op = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
      3'd6:    op = decode_pkg::ALU_OR;
      default: op = decode_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl              = decode_pkg::DECODER_CTRL_ILLEGAL;
    ctrl.illegal_insn = 1'b0;
    illegal           = 1'b0;
    case (opcode)
      `OPC_JAL, `OPC_JALR: begin
        ctrl.alu_en   = 1'b1;
        ctrl.alu_jmp  = 1'b1;
        ctrl.op_a_sel = (opcode == `OPC_JAL) ? decode_pkg::OP_A_PC : decode_pkg::OP_A_REG;
        ctrl.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl.imm_sel  = (opcode == `OPC_JAL) ? decode_pkg::IMM_J : decode_pkg::IMM_I;
        ctrl.rf_we    = 1'b1;                          // Link register
        ctrl.rf_re    = {1'b0, opcode == `OPC_JALR};
        illegal       = (opcode == `OPC_JALR) && (funct3 != 3'd0);
      end
      `OPC_BRANCH: begin
        ctrl.alu_en  = 1'b1;
        ctrl.alu_bch = 1'b1;
        ctrl.imm_sel = decode_pkg::IMM_B;
        ctrl.rf_re   = 2'b11;
        case (funct3)
          3'd0:    ctrl.alu_operator = decode_pkg::ALU_EQ;
          3'd1:    ctrl.alu_operator = decode_pkg::ALU_NE;
          3'd4:    ctrl.alu_operator = decode_pkg::ALU_LT;
          3'd5:    ctrl.alu_operator = decode_pkg::ALU_GE;
          3'd6:    ctrl.alu_operator = decode_pkg::ALU_LTU;
          3'd7:    ctrl.alu_operator = decode_pkg::ALU_GEU;
          default: illegal = 1'b1;                     // funct3 2 and 3
        endcase
      end
      `OPC_LOAD, `OPC_STORE: begin
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = (opcode == `OPC_STORE);
        ctrl.lsu_size = funct3[1:0];
        ctrl.lsu_sext = (opcode == `OPC_LOAD) && !funct3[2];
        ctrl.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl.imm_sel  = (opcode == `OPC_STORE) ? decode_pkg::IMM_S : decode_pkg::IMM_I;
        ctrl.rf_we    = (opcode == `OPC_LOAD);
        ctrl.rf_re    = {opcode == `OPC_STORE, 1'b1};
        // Loads take lbu and lhu only, stores never the unsigned set
        illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'd6) ||
                  ((opcode == `OPC_STORE) && funct3[2]);
      end
      `OPC_OP_IMM: begin
        ctrl.alu_en       = 1'b1;
        ctrl.alu_operator = alu_op(funct3, funct3 == 3'd5 && funct7[5]);
        ctrl.op_b_sel     = decode_pkg::OP_B_IMM;
        ctrl.rf_we        = 1'b1;
        ctrl.rf_re        = 2'b01;
        if (funct3 == 3'd1) illegal = (funct7 != 7'h00);                       // slli
        if (funct3 == 3'd5) illegal = (funct7 != 7'h00) && (funct7 != 7'h20);  // srli, srai
      end
      `OPC_OP: begin
        ctrl.alu_en       = 1'b1;
        ctrl.alu_operator = alu_op(funct3, funct7[5]);
        ctrl.rf_we        = 1'b1;
        ctrl.rf_re        = 2'b11;
        // 7'h01 belongs to the M decoder
        illegal = !((funct7 == 7'h00) ||
                    ((funct7 == 7'h20) && (funct3 == 3'd0 || funct3 == 3'd5)));
      end
      `OPC_LUI, `OPC_AUIPC: begin
        ctrl.alu_en   = 1'b1;
        ctrl.op_a_sel = (opcode == `OPC_LUI) ? decode_pkg::OP_A_ZERO : decode_pkg::OP_A_PC;
        ctrl.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl.imm_sel  = decode_pkg::IMM_U;
        ctrl.rf_we    = 1'b1;
      end
      `OPC_MISC_MEM: begin
        ctrl.sys_en     = 1'b1;                        // FENCE runs as a no-op
        ctrl.sys_fencei = (funct3 == 3'd1);
        illegal         = (funct3[2:1] != 2'b00);
      end
      `OPC_SYSTEM: begin
        if (funct3 == 3'd0) begin
          ctrl.sys_en = 1'b1;
          case (instr_i[31:20])
            12'h000: ctrl.sys_ecall = 1'b1;
            12'h001: ctrl.sys_ebrk  = 1'b1;
            12'h302: ctrl.sys_mret  = 1'b1;
            12'h105: ctrl.sys_wfi   = 1'b1;
            default: illegal        = 1'b1;
          endcase
          if (instr_i[19:7] != '0) illegal = 1'b1;      // rs1 and rd must be x0
        end else begin
          ctrl.csr_en   = 1'b1;
          ctrl.op_b_sel = decode_pkg::OP_B_IMM;        // CSR address
          ctrl.rf_we    = 1'b1;
          ctrl.rf_re    = {1'b0, !funct3[2]};          // Immediate forms read no rs1
          ctrl.csr_op   = decode_pkg::csr_opcode_e'(funct3[1:0]);
          if (funct3[1] && (instr_i[19:15] == 5'd0)) ctrl.csr_op = decode_pkg::CSR_OP_READ;
          illegal = (funct3 == 3'd4);
        end
      end
      default: illegal = 1'b1;
    endcase
    ctrl_o = illegal ? decode_pkg::DECODER_CTRL_ILLEGAL : ctrl;
  end

endmodule

/* decoder/m_decoder.sv */
////////////////////////////////////////
// RV32M decoder
// Multiply and divide, gated by the run-time M enable
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_consts.svh"

module m_decoder (
  input  logic [`INSTR_W-1:0]       instr_i,
  input  logic                      m_en_i,
  output decode_pkg::decoder_ctrl_t ctrl_o
);

  logic match;

  assign match = m_en_i && (instr_i[6:0] == `OPC_OP) && (instr_i[31:25] == 7'b0000001);

  always_comb begin
    ctrl_o = decode_pkg::DECODER_CTRL_ILLEGAL;
    if (match) begin
      ctrl_o.illegal_insn = 1'b0;
      ctrl_o.rf_we        = 1'b1;
      ctrl_o.rf_re        = 2'b11;
      if (instr_i[14]) begin                           // funct3 4..7
        ctrl_o.div_en       = 1'b1;
        ctrl_o.div_operator = decode_pkg::div_opcode_e'(instr_i[13:12]);
      end else begin                                   // funct3 0..3
        ctrl_o.mul_en       = 1'b1;
        ctrl_o.mul_operator = decode_pkg::mul_opcode_e'(instr_i[13:12]);
      end
    end
  end

endmodule

/* decoder/decoder.sv */
////////////////////////////////////////
// Instruction decoder
// I and M decoders, priority mux, illegal override, deassert
////////////////////////////////////////
`timescale 1ns/1ps

module decoder (
  input  logic                      clk,             // Drives the checks below only
  input  pipe_pkg::if_id_pipe_t     if_id_pipe_i,
  input  logic                      m_en_i,
  input  logic                      deassert_we_i,   // From controller
  output decode_pkg::decoder_ctrl_t ctrl_o
);

  decode_pkg::decoder_ctrl_t i_ctrl;
  decode_pkg::decoder_ctrl_t m_ctrl;
  decode_pkg::decoder_ctrl_t mux_ctrl;

  i_decoder i_decoder_i (
    .instr_i (if_id_pipe_i.instr),
    .ctrl_o  (i_ctrl)
  );

  m_decoder m_decoder_i (
    .instr_i (if_id_pipe_i.instr),
    .m_en_i  (m_en_i),
    .ctrl_o  (m_ctrl)
  );

  ////////////////////////////////////////
  // Select and suppress
  ////////////////////////////////////////
  always_comb begin
    if (if_id_pipe_i.illegal_c_insn)  mux_ctrl = decode_pkg::DECODER_CTRL_ILLEGAL;
    else if (!m_ctrl.illegal_insn)    mux_ctrl = m_ctrl;   // M wins
    else if (!i_ctrl.illegal_insn)    mux_ctrl = i_ctrl;
    else                              mux_ctrl = decode_pkg::DECODER_CTRL_ILLEGAL;
  end

  // Operator fields pass, enables drop
  always_comb begin
    ctrl_o = mux_ctrl;
    if (deassert_we_i) begin
      ctrl_o.alu_en       = 1'b0;
      ctrl_o.mul_en       = 1'b0;
      ctrl_o.div_en       = 1'b0;
      ctrl_o.lsu_en       = 1'b0;
      ctrl_o.csr_en       = 1'b0;
      ctrl_o.sys_en       = 1'b0;
      ctrl_o.rf_we        = 1'b0;
      ctrl_o.illegal_insn = 1'b0;
    end
  end

  // Decoder encodings are disjoint
  a_single_match: assert property (@(posedge clk)
    if_id_pipe_i.instr_valid |-> (i_ctrl.illegal_insn || m_ctrl.illegal_insn));

  // One execution unit per instruction
  a_one_unit: assert property (@(posedge clk)
    if_id_pipe_i.instr_valid |-> $onehot0({ctrl_o.alu_en, ctrl_o.mul_en,
                                           ctrl_o.div_en, ctrl_o.lsu_en}));

endmodule

/* rtl/decode_cfg.sv */
////////////////////////////////////////
// Decode configuration
// Run-time M extension enable
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_cfg (
  input  logic clk,
  input  logic rst_n_i,
  input  logic cfg_we_i,     // Write strobe
  input  logic cfg_m_en_i,   // New enable value
  output logic m_en_o
);

  logic m_en_q;

  // New value seen by the decoder from the write edge on
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      m_en_q <= `M_EN_RST;
    end else if (cfg_we_i) begin
      m_en_q <= cfg_m_en_i;
    end
  end

  assign m_en_o = m_en_q;

endmodule

/* rtl/id_ex_reg.sv */
////////////////////////////////////////
// ID/EX pipeline register
// Control word and register indices, one cycle
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_consts.svh"

module id_ex_reg (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      instr_valid_i,
  input  logic [`INSTR_W-1:0]       instr_i,
  input  decode_pkg::decoder_ctrl_t ctrl_i,
  output pipe_pkg::id_ex_pipe_t     id_ex_pipe_o
);

  // Bubble word with every enable low and no trap
  localparam decode_pkg::decoder_ctrl_t CTRL_IDLE = '{
    alu_operator: decode_pkg::ALU_ADD, op_a_sel: decode_pkg::OP_A_REG,
    op_b_sel: decode_pkg::OP_B_REG, imm_sel: decode_pkg::IMM_I,
    mul_operator: decode_pkg::MUL_M, div_operator: decode_pkg::DIV_DIV,
    csr_op: decode_pkg::CSR_OP_READ, default: '0};

  decode_pkg::decoder_ctrl_t ctrl_q;
  logic                      valid_q;
  logic [4:0]                rs1_q, rs2_q, rd_q;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      ctrl_q  <= CTRL_IDLE;
    end else begin
      valid_q <= instr_valid_i;
      ctrl_q  <= instr_valid_i ? ctrl_i : CTRL_IDLE;
    end
  end

  // Register indices
  always_ff @(posedge clk) begin
    rs1_q <= instr_i[19:15];
    rs2_q <= instr_i[24:20];
    rd_q  <= instr_i[11:7];
  end

  assign id_ex_pipe_o = '{valid: valid_q, ctrl: ctrl_q, rs1: rs1_q, rs2: rs2_q, rd: rd_q};

  // Bubbles carry no enable into EX
  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
    !id_ex_pipe_o.valid |-> !(ctrl_q.alu_en || ctrl_q.mul_en || ctrl_q.div_en ||
                              ctrl_q.lsu_en || ctrl_q.csr_en || ctrl_q.sys_en ||
                              ctrl_q.rf_we || ctrl_q.illegal_insn));

endmodule

/* rtl/id_stage.sv */
////////////////////////////////////////
// Instruction decode stage
// Config block, decoder and ID/EX register
////////////////////////////////////////
`timescale 1ns/1ps

module id_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  pipe_pkg::if_id_pipe_t if_id_pipe_i,
  input  logic                  deassert_we_i,
  input  logic                  cfg_we_i,
  input  logic                  cfg_m_en_i,
  output pipe_pkg::id_ex_pipe_t id_ex_pipe_o,
  output logic                  m_en_o
);

  logic                      m_en;
  decode_pkg::decoder_ctrl_t id_ctrl;

  decode_cfg decode_cfg_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_m_en_i (cfg_m_en_i),
    .m_en_o     (m_en)
  );

  decoder decoder_i (
    .clk           (clk),
    .if_id_pipe_i  (if_id_pipe_i),
    .m_en_i        (m_en),
    .deassert_we_i (deassert_we_i),
    .ctrl_o        (id_ctrl)
  );

  id_ex_reg id_ex_reg_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (if_id_pipe_i.instr_valid),
    .instr_i       (if_id_pipe_i.instr),
    .ctrl_i        (id_ctrl),
    .id_ex_pipe_o  (id_ex_pipe_o)
  );

  assign m_en_o = m_en;   // Current M enable

endmodule

/* test/tb_decode_model.svh */
////////////////////////////////////////
// Decode reference model
// Expected ID/EX word per instruction, plus the LFSR
////////////////////////////////////////
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

`include "decode_consts.svh"

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// ALU operator for OP and OP-IMM, alt selects sub or sra
function automatic decode_pkg::alu_opcode_e alu_expect(input logic alt, input logic [2:0] f3);
  decode_pkg::alu_opcode_e op;
  casez ({alt, f3})
    4'b0000: op = decode_pkg::ALU_ADD;
    4'b1000: op = decode_pkg::ALU_SUB;
    4'b?001: op = decode_pkg::ALU_SLL;
    4'b?010: op = decode_pkg::ALU_SLT;
    4'b?011: op = decode_pkg::ALU_SLTU;
    4'b?100: op = decode_pkg::ALU_XOR;
    4'b0101: op = decode_pkg::ALU_SRL;
    4'b1101: op = decode_pkg::ALU_SRA;
    4'b?110: op = decode_pkg::ALU_OR;
    default: op = decode_pkg::ALU_AND;
  endcase
  return op;
endfunction

////////////////////////////////////////
// Base integer set
////////////////////////////////////////
function automatic decode_pkg::decoder_ctrl_t expect_base(input logic [31:0] w,
                                                          output logic legal_o);
  decode_pkg::decoder_ctrl_t c;
  logic [2:0]                f3;
  logic [6:0]                f7;
  f3             = w[14:12];
  f7             = w[31:25];
  c              = decode_pkg::DECODER_CTRL_ILLEGAL;
  c.illegal_insn = 1'b0;
  legal_o        = 1'b1;
  case (w[6:0])
    `OPC_OP, `OPC_OP_IMM: begin
      c.alu_en       = 1'b1;
      c.alu_operator = alu_expect(f7[5] && (w[6:0] == `OPC_OP || f3 == 3'd5), f3);
      c.rf_we        = 1'b1;
      if (w[6:0] == `OPC_OP) begin
        c.rf_re = 2'b11;
        legal_o = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end else begin
        c.rf_re    = 2'b01;
        c.op_b_sel = decode_pkg::OP_B_IMM;
        if (f3 == 3'd1) legal_o = (f7 == 7'h00);                  // Shift amount only
        if (f3 == 3'd5) legal_o = (f7 == 7'h00) || (f7 == 7'h20);
      end
    end
    `OPC_LUI, `OPC_AUIPC: begin
      c.alu_en   = 1'b1;
      c.op_a_sel = (w[6:0] == `OPC_AUIPC) ? decode_pkg::OP_A_PC : decode_pkg::OP_A_ZERO;
      c.op_b_sel = decode_pkg::OP_B_IMM;
      c.imm_sel  = decode_pkg::IMM_U;
      c.rf_we    = 1'b1;
    end
    `OPC_JAL: begin
      c.alu_en   = 1'b1;
      c.alu_jmp  = 1'b1;
      c.op_a_sel = decode_pkg::OP_A_PC;
      c.op_b_sel = decode_pkg::OP_B_IMM;
      c.imm_sel  = decode_pkg::IMM_J;
      c.rf_we    = 1'b1;
    end
    `OPC_JALR: begin
      c.alu_en   = 1'b1;
      c.alu_jmp  = 1'b1;
      c.op_b_sel = decode_pkg::OP_B_IMM;
      c.rf_we    = 1'b1;
      c.rf_re    = 2'b01;
      legal_o    = (f3 == 3'd0);
    end
    `OPC_BRANCH: begin
      c.alu_en  = 1'b1;
      c.alu_bch = 1'b1;
      c.imm_sel = decode_pkg::IMM_B;
      c.rf_re   = 2'b11;
      case (f3)
        3'd0:    c.alu_operator = decode_pkg::ALU_EQ;
        3'd1:    c.alu_operator = decode_pkg::ALU_NE;
        3'd4:    c.alu_operator = decode_pkg::ALU_LT;
        3'd5:    c.alu_operator = decode_pkg::ALU_GE;
        3'd6:    c.alu_operator = decode_pkg::ALU_LTU;
        3'd7:    c.alu_operator = decode_pkg::ALU_GEU;
        default: legal_o        = 1'b0;
      endcase
    end
    `OPC_LOAD: begin
      c.lsu_en   = 1'b1;
      c.lsu_size = f3[1:0];
      c.lsu_sext = ~f3[2];                    // lbu and lhu zero extend
      c.op_b_sel = decode_pkg::OP_B_IMM;
      c.rf_we    = 1'b1;
      c.rf_re    = 2'b01;
      legal_o    = !(f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7);
    end
    `OPC_STORE: begin
      c.lsu_en   = 1'b1;
      c.lsu_we   = 1'b1;
      c.lsu_size = f3[1:0];
      c.op_b_sel = decode_pkg::OP_B_IMM;
      c.imm_sel  = decode_pkg::IMM_S;
      c.rf_re    = 2'b11;                     // Base and data
      legal_o    = (f3 <= 3'd2);
    end
    `OPC_MISC_MEM: begin
      c.sys_en     = 1'b1;
      c.sys_fencei = (f3 == 3'd1);
      legal_o      = (f3 <= 3'd1);
    end
    `OPC_SYSTEM: begin
      if (f3 == 3'd0) begin
        c.sys_en = 1'b1;
        case (w[31:20])
          12'h000: c.sys_ecall = 1'b1;
          12'h001: c.sys_ebrk  = 1'b1;
          12'h302: c.sys_mret  = 1'b1;
          12'h105: c.sys_wfi   = 1'b1;
          default: legal_o     = 1'b0;
        endcase
        if (w[19:7] != 13'd0) legal_o = 1'b0;
      end else begin
        c.csr_en   = 1'b1;
        c.op_b_sel = decode_pkg::OP_B_IMM;
        c.rf_we    = 1'b1;
        c.rf_re    = {1'b0, ~f3[2]};
        // Set or clear with a zero source only reads
        case (f3[1:0])
          2'd1:    c.csr_op = decode_pkg::CSR_OP_WRITE;
          2'd2:    c.csr_op = (w[19:15] == 5'd0) ? decode_pkg::CSR_OP_READ : decode_pkg::CSR_OP_SET;
          default: c.csr_op = (w[19:15] == 5'd0) ? decode_pkg::CSR_OP_READ : decode_pkg::CSR_OP_CLEAR;
        endcase
        legal_o = (f3 != 3'd4);
      end
    end
    default: legal_o = 1'b0;
  endcase
  return c;
endfunction

////////////////////////////////////////
// Whole stage, one cycle later
////////////////////////////////////////
function automatic pipe_pkg::id_ex_pipe_t expect_stage(input logic [31:0] w, input logic vld,
                                                       input logic c_ill, input logic m_en,
                                                       input logic dea);
  decode_pkg::decoder_ctrl_t c;
  logic                      base_ok;
  c = expect_base(w, base_ok);
  if (m_en && w[6:0] == `OPC_OP && w[31:25] == 7'b0000001) begin
    c              = decode_pkg::DECODER_CTRL_ILLEGAL;
    c.illegal_insn = 1'b0;
    c.rf_we        = 1'b1;
    c.rf_re        = 2'b11;
    c.mul_en       = ~w[14];                  // Funct3 0 to 3
    c.div_en       = w[14];                   // Funct3 4 to 7
    case (w[14:12])
      3'd0:    c.mul_operator = decode_pkg::MUL_M;
      3'd1:    c.mul_operator = decode_pkg::MUL_H;
      3'd2:    c.mul_operator = decode_pkg::MUL_HSU;
      3'd3:    c.mul_operator = decode_pkg::MUL_HU;
      3'd4:    c.div_operator = decode_pkg::DIV_DIV;
      3'd5:    c.div_operator = decode_pkg::DIV_DIVU;
      3'd6:    c.div_operator = decode_pkg::DIV_REM;
      default: c.div_operator = decode_pkg::DIV_REMU;
    endcase
  end else if (!base_ok) begin
    c = decode_pkg::DECODER_CTRL_ILLEGAL;
  end
  if (c_ill) c = decode_pkg::DECODER_CTRL_ILLEGAL;
  if (dea) begin
    c.alu_en       = 1'b0;
    c.mul_en       = 1'b0;
    c.div_en       = 1'b0;
    c.lsu_en       = 1'b0;
    c.csr_en       = 1'b0;
    c.sys_en       = 1'b0;
    c.rf_we        = 1'b0;
    c.illegal_insn = 1'b0;
  end
  if (!vld) begin                             // Bubble
    c              = decode_pkg::DECODER_CTRL_ILLEGAL;
    c.illegal_insn = 1'b0;
  end
  return '{valid: vld, ctrl: c, rs1: w[19:15], rs2: w[24:20], rd: w[11:7]};
endfunction

`endif

/* test/tb_id_stage.sv */
////////////////////////////////////////
// Decode stage testbench
// Random and directed words against the reference model
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_id_stage;

  `include "tb_decode_model.svh"

  // Vector counts per section, the watchdog uses the sum
  localparam int RST_VEC   = 4;
  localparam int RAND_VEC  = 240;
  localparam int M_VEC     = 19;
  localparam int ILL_VEC   = 32;
  localparam int SUP_VEC   = 60;
  localparam int DRAIN_VEC = 3;
  localparam int N_VEC     = RST_VEC + RAND_VEC + M_VEC + ILL_VEC + SUP_VEC + DRAIN_VEC;

  logic                  clk;
  logic                  rst_n_i;
  pipe_pkg::if_id_pipe_t if_id_pipe_i;
  logic                  deassert_we_i;
  logic                  cfg_we_i;
  logic                  cfg_m_en_i;
  pipe_pkg::id_ex_pipe_t id_ex_pipe_o;
  logic                  m_en_o;

  logic [31:0]           lfsr_q;
  logic                  hold_reset;
  logic                  check_en;
  logic                  m_en_model;        // Enable the DUT holds now
  logic                  m_en_chk;
  pipe_pkg::id_ex_pipe_t exp_next;          // For the word just driven
  pipe_pkg::id_ex_pipe_t exp_out;           // For the word now at the output
  string                 name_next;
  string                 name_out;

  id_stage DUT (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .if_id_pipe_i  (if_id_pipe_i),
    .deassert_we_i (deassert_we_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_m_en_i    (cfg_m_en_i),
    .id_ex_pipe_o  (id_ex_pipe_o),
    .m_en_o        (m_en_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  // Fixed funct7, funct3 and opcode, random register fields
  function automatic logic [31:0] make_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [6:0] opc);
    logic [31:0] r;
    r = rand_bits(32);
    return {f7, r[24:15], f3, r[11:7], opc};
  endfunction

  // Legal RV32I word from an opcode template
  function automatic logic [31:0] rand_rv32i();
    logic [31:0] w;
    logic [31:0] sel;
    w   = rand_bits(32);
    sel = rand_bits(4) % 12;
    case (sel)
      0: begin
        w[6:0]   = `OPC_OP;
        w[31:25] = (w[14:12] == 3'd0 || w[14:12] == 3'd5) ? {1'b0, w[31], 5'd0} : 7'h00;
      end
      1: begin
        w[6:0] = `OPC_OP_IMM;
        if (w[14:12] == 3'd1) w[31:25] = 7'h00;
        if (w[14:12] == 3'd5) w[31:25] = {1'b0, w[31], 5'd0};   // srli or srai
      end
      2: begin
        w[6:0] = `OPC_LOAD;
        w[13]  = w[13] & ~w[12] & ~w[14];     // Funct3 0, 1, 2, 4, 5
      end
      3: begin
        w[6:0] = `OPC_STORE;
        w[14]  = 1'b0;
        w[13]  = w[13] & ~w[12];
      end
      4: begin
        w[6:0] = `OPC_BRANCH;
        if (w[14:13] == 2'b01) w[13] = 1'b0;  // No compare at 2 and 3
      end
      5: w[6:0] = `OPC_JAL;
      6: begin
        w[6:0]   = `OPC_JALR;
        w[14:12] = 3'd0;
      end
      7: w[6:0] = `OPC_LUI;
      8: w[6:0] = `OPC_AUIPC;
      9: begin
        w[6:0]   = `OPC_MISC_MEM;
        w[14:13] = 2'b00;
      end
      10: begin
        w[6:0] = `OPC_SYSTEM;
        if (w[13:12] == 2'b00) w[12] = 1'b1;  // Off the ECALL space and funct3 4
      end
      default: begin
        case (rand_bits(2))
          0:       w = {12'h000, 13'd0, `OPC_SYSTEM};
          1:       w = {12'h001, 13'd0, `OPC_SYSTEM};
          2:       w = {12'h302, 13'd0, `OPC_SYSTEM};
          default: w = {12'h105, 13'd0, `OPC_SYSTEM};
        endcase
      end
    endcase
    return w;
  endfunction

  // One cycle of input, driven on the falling edge
  task automatic step(input string name, input logic [31:0] w, input logic vld,
                      input logic c_ill, input logic dea, input logic we, input logic we_val);
    @(negedge clk);
    exp_out       = exp_next;
    name_out      = name_next;
    m_en_chk      = m_en_model;
    check_en      = 1'b1;
    rst_n_i       = !hold_reset;
    if_id_pipe_i  = '{instr_valid: vld, instr: w, illegal_c_insn: c_ill};
    deassert_we_i = dea;
    cfg_we_i      = we;
    cfg_m_en_i    = we_val;
    name_next     = name;
    if (hold_reset) begin
      exp_next   = expect_stage(w, 1'b0, 1'b0, 1'b0, 1'b0);
      m_en_model = `M_EN_RST;
    end else begin
      exp_next = expect_stage(w, vld, c_ill, m_en_model, dea);   // Old enable decodes
      if (we) m_en_model = we_val;
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  a_stage_out: assert property (@(posedge clk) disable iff (!check_en)
    id_ex_pipe_o == exp_out)
    else begin
      $display("mismatch %s expected %h actual %h", name_out, exp_out, $sampled(id_ex_pipe_o));
      $display("TB FAILED");
      $fatal(1);
    end

  a_m_en: assert property (@(posedge clk) disable iff (!check_en) m_en_o == m_en_chk)
    else begin
      $display("mismatch m_en %s expected %b actual %b", name_out, m_en_chk, $sampled(m_en_o));
      $display("TB FAILED");
      $fatal(1);
    end

  initial begin
    #((N_VEC + 20) * 100);
    $display("watchdog: run timed out before all vectors were applied");
    $display("TB FAILED");
    $fatal(1);
  end

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] w;
    rst_n_i       = 1'b0;
    if_id_pipe_i  = '0;
    deassert_we_i = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_m_en_i    = 1'b0;
    lfsr_q        = 32'hafd7f4d9;
    hold_reset    = 1'b1;
    check_en      = 1'b0;
    m_en_model    = `M_EN_RST;
    m_en_chk      = `M_EN_RST;
    exp_next      = expect_stage('0, 1'b0, 1'b0, 1'b0, 1'b0);
    exp_out       = exp_next;
    name_next     = "reset";
    name_out      = "reset";

    // Reset wins over live words and a config write
    repeat (RST_VEC) step("reset", rand_rv32i(), 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    hold_reset = 1'b0;
    step("reset release", '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    repeat (RAND_VEC) step("rv32i", rand_rv32i(), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);

    // M extension on, then cleared with a mul in the write cycle
    step("m_ext enable", '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    for (int f = 0; f < 8; f++) step("m_ext on", make_word(7'h01, f[2:0], `OPC_OP),
                                     1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    step("m_ext write", make_word(7'h01, 3'd0, `OPC_OP), 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    for (int f = 0; f < 8; f++) step("m_ext off", make_word(7'h01, f[2:0], `OPC_OP),
                                     1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    step("m_ext restore", '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);

    // Illegal encodings
    for (int i = 0; i < 8; i++) begin
      w = rand_bits(32);
      step("undef opcode", {w[31:7], i[2:0], 4'b1011}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      step("undef opcode", {w[31:7], i[2:0], 4'b0100}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    for (int f = 3; f < 8; f++) begin
      if (f != 4 && f != 5) step("bad load", make_word(7'h15, f[2:0], `OPC_LOAD),
                                 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      step("bad store", make_word(7'h2a, f[2:0], `OPC_STORE), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    step("bad shift", make_word(7'h20, 3'd1, `OPC_OP_IMM), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    step("bad shift", make_word(7'h01, 3'd5, `OPC_OP_IMM), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    step("bad shift", make_word(7'h20, 3'd1, `OPC_OP), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    step("bad shift", make_word(7'h40, 3'd5, `OPC_OP), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (4) step("illegal c", rand_rv32i(), 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);

    // Deassert and bubbles
    repeat (30) step("deassert", rand_rv32i(), 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    repeat (10) step("deassert any", rand_bits(32), 1'b1, coin(), 1'b1, 1'b0, 1'b0);
    repeat (20) step("bubble", rand_bits(32), 1'b0, coin(), coin(), 1'b0, 1'b0);

    // Flush the last words through the checks
    repeat (DRAIN_VEC - 1) step("drain", '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(posedge clk);
    @(negedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common/
+incdir+test/
common/decode_pkg.sv
common/pipe_pkg.sv
decoder/i_decoder.sv
decoder/m_decoder.sv
decoder/decoder.sv
rtl/decode_cfg.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
test/tb_id_stage.sv
